/* vmux_pkg.sv */
// shared widths, encodings and result payloads of the execution back end
// both payload structs are packed and their layout is fixed by the widths below
package vmux_pkg;

    localparam int unsigned DATA_W        = 32;
    localparam int unsigned ID_W          = 3;
    localparam int unsigned VADDR_W       = 5;
    localparam int unsigned SCRATCH_DEPTH = 16;
    localparam int unsigned CNT_W         = 2;

    typedef enum logic {
        UNIT_ARITH = 1'b0,
        UNIT_LSU   = 1'b1
    } unit_e;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_XOR,
        OP_MUL,
        OP_LOAD,
        OP_STORE
    } op_e;

    // 41 bits
    typedef struct packed {
        logic [ID_W-1:0]    id;
        logic [VADDR_W-1:0] vaddr;
        logic [DATA_W-1:0]  data;
        logic               done;
    } arith_beat_t;

    // 42 bits, wr is low for stores
    typedef struct packed {
        logic [ID_W-1:0]    id;
        logic [VADDR_W-1:0] vaddr;
        logic [DATA_W-1:0]  data;
        logic               wr;
        logic               done;
    } lsu_beat_t;

endpackage

/* pipe_stage.sv */
// single-entry register slice, full throughput when the consumer keeps ready high
// the payload register has no reset, only the valid bit does
`timescale 1ns/1ps

module pipe_stage #(
    parameter type PAYLOAD_T = logic
) (
    input  logic     clk_i,
    input  logic     async_rst_ni,
    input  logic     in_valid_i,
    output logic     in_ready_o,
    input  PAYLOAD_T in_data_i,
    output logic     out_valid_o,
    input  logic     out_ready_i,
    output PAYLOAD_T out_data_o
);

    logic     valid_q;
    PAYLOAD_T data_q;

    // accept when empty or when the held beat leaves this cycle
    assign in_ready_o  = ~valid_q | out_ready_i;
    assign out_valid_o = valid_q;
    assign out_data_o  = data_q;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_valid_i && in_ready_o) begin
            data_q <= in_data_i;
        end
    end

    // a stalled beat must not change or vanish
    assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o));

endmodule

/* arith_unit.sv */
// add, sub, xor and low half of the product, one cycle of latency
// every arithmetic result is a register write, so the output has no wr flag
`timescale 1ns/1ps

module arith_unit (
    input  logic                         clk_i,
    input  logic                         async_rst_ni,
    input  logic                         in_valid_i,
    output logic                         in_ready_o,
    input  vmux_pkg::op_e                in_op_i,
    input  logic                         in_last_i,
    input  logic [vmux_pkg::ID_W-1:0]    in_id_i,
    input  logic [vmux_pkg::VADDR_W-1:0] in_vaddr_i,
    input  logic [vmux_pkg::DATA_W-1:0]  in_opa_i,
    input  logic [vmux_pkg::DATA_W-1:0]  in_opb_i,
    output logic                         out_valid_o,
    input  logic                         out_ready_i,
    output vmux_pkg::arith_beat_t        out_beat_o
);

    import vmux_pkg::*;

    arith_beat_t beat;

    always_comb begin
        beat.id    = in_id_i;
        beat.vaddr = in_vaddr_i;
        beat.done  = in_last_i;
        case (in_op_i)
            OP_ADD:  beat.data = in_opa_i + in_opb_i;
            OP_SUB:  beat.data = in_opa_i - in_opb_i;
            OP_XOR:  beat.data = in_opa_i ^ in_opb_i;
            // truncation keeps the low 32 bits of the product
            OP_MUL:  beat.data = in_opa_i * in_opb_i;
            default: beat.data = '0;
        endcase
    end

    pipe_stage #(
        .PAYLOAD_T   (arith_beat_t)
    ) stage0 (
        .clk_i       (clk_i),
        .async_rst_ni(async_rst_ni),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .in_data_i   (beat),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_data_o  (out_beat_o)
    );

    // the scheduler routes memory ops elsewhere
    assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        in_valid_i |-> in_op_i inside {OP_ADD, OP_SUB, OP_XOR, OP_MUL});

endmodule

/* lsu_unit.sv */
// loads and stores on a local scratch memory, word index from the low bits of opa
// stores write on the input transfer, a load right behind a store sees the new word
`timescale 1ns/1ps

module lsu_unit #(
    parameter int unsigned DEPTH = vmux_pkg::SCRATCH_DEPTH
) (
    input  logic                         clk_i,
    input  logic                         async_rst_ni,
    input  logic                         in_valid_i,
    output logic                         in_ready_o,
    input  vmux_pkg::op_e                in_op_i,
    input  logic                         in_last_i,
    input  logic [vmux_pkg::ID_W-1:0]    in_id_i,
    input  logic [vmux_pkg::VADDR_W-1:0] in_vaddr_i,
    input  logic [vmux_pkg::DATA_W-1:0]  in_opa_i,
    input  logic [vmux_pkg::DATA_W-1:0]  in_opb_i,
    output logic                         out_valid_o,
    input  logic                         out_ready_i,
    output vmux_pkg::lsu_beat_t          out_beat_o
);

    import vmux_pkg::*;

    localparam int unsigned IDX_W = $clog2(DEPTH);

    logic [DATA_W-1:0] mem [DEPTH];
    logic [IDX_W-1:0]  idx;
    lsu_beat_t         beat;

    assign idx = in_opa_i[IDX_W-1:0];

    always_ff @(posedge clk_i) begin
        if (in_valid_i && in_ready_o && in_op_i == OP_STORE) begin
            mem[idx] <= in_opb_i;
        end
    end

    // store beats carry the old word, it is ignored downstream since wr is low
    always_comb begin
        beat.id    = in_id_i;
        beat.vaddr = in_vaddr_i;
        beat.data  = mem[idx];
        beat.wr    = (in_op_i == OP_LOAD);
        beat.done  = in_last_i;
    end

    pipe_stage #(
        .PAYLOAD_T   (lsu_beat_t)
    ) stage0 (
        .clk_i       (clk_i),
        .async_rst_ni(async_rst_ni),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .in_data_i   (beat),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_data_o  (out_beat_o)
    );

endmodule

/* unit_scheduler.sv */
// dispatch to one of two units and merge their results without splitting instructions
// in_ready_o is low while no beat is offered; the lsu counter holds at most 3 instructions
`timescale 1ns/1ps

module unit_scheduler #(
    parameter int unsigned CNT_W = vmux_pkg::CNT_W
) (
    input  logic                         clk_i,
    input  logic                         async_rst_ni,
    input  logic                         arith_en_i,
    input  logic                         lsu_en_i,
    input  logic                         in_valid_i,
    output logic                         in_ready_o,
    input  vmux_pkg::unit_e              in_unit_i,
    input  logic                         in_first_i,
    input  logic                         in_last_i,
    output logic                         arith_valid_o,
    input  logic                         arith_ready_i,
    output logic                         lsu_valid_o,
    input  logic                         lsu_ready_i,
    input  logic                         arith_out_valid_i,
    output logic                         arith_out_ready_o,
    input  vmux_pkg::arith_beat_t        arith_out_beat_i,
    input  logic                         lsu_out_valid_i,
    output logic                         lsu_out_ready_o,
    input  vmux_pkg::lsu_beat_t          lsu_out_beat_i,
    output logic                         out_valid_o,
    input  logic                         out_ready_i,
    output logic [vmux_pkg::ID_W-1:0]    out_id_o,
    output logic [vmux_pkg::VADDR_W-1:0] out_vaddr_o,
    output logic                         out_wr_o,
    output logic [vmux_pkg::DATA_W-1:0]  out_data_o,
    output logic                         out_done_o,
    output logic [CNT_W-1:0]             lsu_cnt_o,
    output logic                         lock_valid_o
);

    import vmux_pkg::*;

    logic             is_lsu;
    logic             cnt_inc;
    logic             cnt_dec;
    logic [CNT_W-1:0] cnt_q;
    logic             lock_q;
    unit_e            active_q;
    logic [ID_W-1:0]  lock_id_q;
    unit_e            sel;
    logic             out_fire;
    logic             in_open_q;
    unit_e            in_unit_q;

    // a disabled unit sees no valid, so it cannot take the beat behind our back
    assign is_lsu        = (in_unit_i == UNIT_LSU);
    assign arith_valid_o = in_valid_i & ~is_lsu & arith_en_i;
    assign lsu_valid_o   = in_valid_i & is_lsu & lsu_en_i;
    assign in_ready_o    = is_lsu ? (lsu_valid_o & lsu_ready_i) : (arith_valid_o & arith_ready_i);

    assign cnt_inc = lsu_valid_o & lsu_ready_i & in_first_i;
    assign cnt_dec = lsu_out_valid_i & lsu_out_ready_o & lsu_out_beat_i.done;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            cnt_q <= '0;
        end else if (cnt_inc != cnt_dec) begin
            cnt_q <= cnt_inc ? cnt_q + CNT_W'(1) : cnt_q - CNT_W'(1);
        end
    end

    // lock first, then a busy lsu even before its data shows up, then lowest valid unit
    always_comb begin
        sel = UNIT_ARITH;
        if (lock_q) begin
            sel = active_q;
        end else if (cnt_q != '0) begin
            sel = UNIT_LSU;
        end else if (!arith_out_valid_i) begin
            sel = UNIT_LSU;
        end
    end

    assign arith_out_ready_o = out_ready_i & (sel == UNIT_ARITH);
    assign lsu_out_ready_o   = out_ready_i & (sel == UNIT_LSU);
    assign out_valid_o       = (sel == UNIT_LSU) ? lsu_out_valid_i : arith_out_valid_i;
    assign out_fire          = out_valid_o & out_ready_i;

    always_comb begin
        if (sel == UNIT_LSU) begin
            out_id_o    = lsu_out_beat_i.id;
            out_vaddr_o = lsu_out_beat_i.vaddr;
            out_wr_o    = lsu_out_beat_i.wr;
            out_data_o  = lsu_out_beat_i.data;
            out_done_o  = lsu_out_beat_i.done;
        end else begin
            out_id_o    = arith_out_beat_i.id;
            out_vaddr_o = arith_out_beat_i.vaddr;
            out_wr_o    = 1'b1;
            out_data_o  = arith_out_beat_i.data;
            out_done_o  = arith_out_beat_i.done;
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            lock_q    <= 1'b0;
            active_q  <= UNIT_ARITH;
            lock_id_q <= '0;
        end else if (out_fire) begin
            lock_q    <= ~out_done_o;
            active_q  <= sel;
            lock_id_q <= out_id_o;
        end
    end

    // input side instruction tracking, only checked below
    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            in_open_q <= 1'b0;
            in_unit_q <= UNIT_ARITH;
        end else if (in_valid_i && in_ready_o) begin
            in_open_q <= ~in_last_i;
            in_unit_q <= in_unit_i;
        end
    end

    assign lsu_cnt_o    = cnt_q;
    assign lock_valid_o = lock_q;

    assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        cnt_inc && !cnt_dec |-> cnt_q != '1);

    assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        cnt_dec && !cnt_inc |-> cnt_q != '0);

    // under a lock only beats of the instruction that took it may leave
    assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        lock_q && out_fire |-> out_id_o == lock_id_q);

    // follow-on beats belong to the instruction that is open on the input
    assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        in_valid_i && in_ready_o |->
            (in_first_i ? !in_open_q : (in_open_q && in_unit_i == in_unit_q)));

endmodule

/* apb_regs.sv */
// apb slave with zero wait states, CTRL at 0x0 and read-only STATUS at 0x4
// writes to STATUS are ignored, other addresses answer with pslverr
`timescale 1ns/1ps

module apb_regs #(
    parameter int unsigned CNT_W = vmux_pkg::CNT_W
) (
    input  logic             clk_i,
    input  logic             async_rst_ni,
    input  logic [3:0]       paddr_i,
    input  logic             psel_i,
    input  logic             penable_i,
    input  logic             pwrite_i,
    input  logic [31:0]      pwdata_i,
    output logic [31:0]      prdata_o,
    output logic             pready_o,
    output logic             pslverr_o,
    input  logic [CNT_W-1:0] lsu_cnt_i,
    input  logic             lock_valid_i,
    output logic             arith_en_o,
    output logic             lsu_en_o
);

    localparam logic [3:0] ADDR_CTRL   = 4'h0;
    localparam logic [3:0] ADDR_STATUS = 4'h4;

    logic [1:0] ctrl_q;
    logic       access;
    logic       addr_ok;

    assign access  = psel_i & penable_i;
    assign addr_ok = (paddr_i == ADDR_CTRL) || (paddr_i == ADDR_STATUS);

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            ctrl_q <= 2'b11;
        end else if (access && pwrite_i && paddr_i == ADDR_CTRL) begin
            ctrl_q <= pwdata_i[1:0];
        end
    end

    always_comb begin
        prdata_o = '0;
        case (paddr_i)
            ADDR_CTRL:   prdata_o[1:0] = ctrl_q;
            ADDR_STATUS: prdata_o[CNT_W:0] = {lock_valid_i, lsu_cnt_i};
            default:     prdata_o = '0;
        endcase
    end

    assign pready_o   = 1'b1;
    assign pslverr_o  = access & ~addr_ok;
    assign arith_en_o = ctrl_q[0];
    assign lsu_en_o   = ctrl_q[1];

endmodule

/* vunit_mux_top.sv */
// two-unit execution back end with an apb control block
// operands fan out to both units, the scheduler decides which one sees valid
`timescale 1ns/1ps

module vunit_mux_top #(
    parameter int unsigned SCRATCH_DEPTH = vmux_pkg::SCRATCH_DEPTH,
    parameter int unsigned CNT_W         = vmux_pkg::CNT_W
) (
    input  logic                         clk_i,
    input  logic                         async_rst_ni,
    input  logic                         in_valid_i,
    output logic                         in_ready_o,
    input  vmux_pkg::unit_e              in_unit_i,
    input  vmux_pkg::op_e                in_op_i,
    input  logic                         in_first_i,
    input  logic                         in_last_i,
    input  logic [vmux_pkg::ID_W-1:0]    in_id_i,
    input  logic [vmux_pkg::VADDR_W-1:0] in_vaddr_i,
    input  logic [vmux_pkg::DATA_W-1:0]  in_opa_i,
    input  logic [vmux_pkg::DATA_W-1:0]  in_opb_i,
    output logic                         out_valid_o,
    input  logic                         out_ready_i,
    output logic [vmux_pkg::ID_W-1:0]    out_id_o,
    output logic [vmux_pkg::VADDR_W-1:0] out_vaddr_o,
    output logic                         out_wr_o,
    output logic [vmux_pkg::DATA_W-1:0]  out_data_o,
    output logic                         out_done_o,
    input  logic [3:0]                   paddr_i,
    input  logic                         psel_i,
    input  logic                         penable_i,
    input  logic                         pwrite_i,
    input  logic [31:0]                  pwdata_i,
    output logic [31:0]                  prdata_o,
    output logic                         pready_o,
    output logic                         pslverr_o
);

    import vmux_pkg::*;

    logic             arith_valid, arith_ready, arith_out_valid, arith_out_ready;
    logic             lsu_valid, lsu_ready, lsu_out_valid, lsu_out_ready;
    arith_beat_t      arith_out_beat;
    lsu_beat_t        lsu_out_beat;
    logic             arith_en, lsu_en, lock_valid;
    logic [CNT_W-1:0] lsu_cnt;

    arith_unit arith0 (
        .clk_i, .async_rst_ni,
        .in_valid_i (arith_valid),     .in_ready_o (arith_ready),
        .in_op_i, .in_last_i, .in_id_i, .in_vaddr_i, .in_opa_i, .in_opb_i,
        .out_valid_o(arith_out_valid), .out_ready_i(arith_out_ready),
        .out_beat_o (arith_out_beat)
    );

    lsu_unit #(.DEPTH(SCRATCH_DEPTH)) lsu0 (
        .clk_i, .async_rst_ni,
        .in_valid_i (lsu_valid),       .in_ready_o (lsu_ready),
        .in_op_i, .in_last_i, .in_id_i, .in_vaddr_i, .in_opa_i, .in_opb_i,
        .out_valid_o(lsu_out_valid),   .out_ready_i(lsu_out_ready),
        .out_beat_o (lsu_out_beat)
    );

    unit_scheduler #(.CNT_W(CNT_W)) sched0 (
        .clk_i, .async_rst_ni,
        .arith_en_i       (arith_en),        .lsu_en_i        (lsu_en),
        .in_valid_i, .in_ready_o, .in_unit_i, .in_first_i, .in_last_i,
        .arith_valid_o    (arith_valid),     .arith_ready_i   (arith_ready),
        .lsu_valid_o      (lsu_valid),       .lsu_ready_i     (lsu_ready),
        .arith_out_valid_i(arith_out_valid), .arith_out_ready_o(arith_out_ready),
        .arith_out_beat_i (arith_out_beat),
        .lsu_out_valid_i  (lsu_out_valid),   .lsu_out_ready_o (lsu_out_ready),
        .lsu_out_beat_i   (lsu_out_beat),
        .out_valid_o, .out_ready_i, .out_id_o, .out_vaddr_o, .out_wr_o,
        .out_data_o, .out_done_o,
        .lsu_cnt_o        (lsu_cnt),         .lock_valid_o    (lock_valid)
    );

    apb_regs #(.CNT_W(CNT_W)) regs0 (
        .clk_i, .async_rst_ni,
        .paddr_i, .psel_i, .penable_i, .pwrite_i, .pwdata_i,
        .prdata_o, .pready_o, .pslverr_o,
        .lsu_cnt_i   (lsu_cnt),  .lock_valid_i(lock_valid),
        .arith_en_o  (arith_en), .lsu_en_o    (lsu_en)
    );

endmodule

/* tb_vunit_mux.sv */
// self-checking testbench, beats and expected results come from vunit_patterns.txt
// run from the project root; instructions in flight at the same time need distinct ids
`timescale 1ns/1ps

module tb_vunit_mux;

    import vmux_pkg::*;

    localparam logic [3:0] ADDR_CTRL = 4'h0;
    localparam int         MAX_WAIT  = 1000;

    logic        clk_i       = 1'b0;
    logic        out_ready_i = 1'b0;
    logic        async_rst_ni;
    logic        in_valid_i;
    logic        in_ready_o;
    unit_e       in_unit_i;
    op_e         in_op_i;
    logic        in_first_i;
    logic        in_last_i;
    logic [2:0]  in_id_i;
    logic [4:0]  in_vaddr_i;
    logic [31:0] in_opa_i;
    logic [31:0] in_opb_i;
    logic        out_valid_o;
    logic [2:0]  out_id_o;
    logic [4:0]  out_vaddr_o;
    logic        out_wr_o;
    logic [31:0] out_data_o;
    logic        out_done_o;
    logic [3:0]  paddr_i;
    logic        psel_i;
    logic        penable_i;
    logic        pwrite_i;
    logic [31:0] pwdata_i;
    logic [31:0] prdata_o;
    logic        pready_o;
    logic        pslverr_o;

    // expected entry is {vaddr, wr, data, done}
    logic [38:0] exp_q [8][$];
    logic [38:0] mon_exp;
    logic [31:0] lfsr = 32'hebd;
    logic [1:0]  ctrl_shadow = 2'b11;
    logic        open_valid = 1'b0;
    logic [2:0]  open_id = 3'd0;
    logic        timed_out = 1'b0;
    int          errors = 0;
    int          mon_errors = 0;
    int          in_beats = 0;
    int          out_beats = 0;

    vunit_mux_top dut0 (.*);

    always #5 clk_i = ~clk_i;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int value_mismatch(input string name, input logic [31:0] expected,
                                          input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            return 1;
        end
        return 0;
    endfunction

    task automatic print_counts();
        $display("errors %0d, beats in %0d, beats out %0d", errors + mon_errors, in_beats,
                 out_beats);
    endtask

    task automatic report_timeout(input string what);
        errors++;
        timed_out = 1'b1;
        $display("timeout after %0d cycles while waiting for %s", MAX_WAIT, what);
    endtask

    always @(negedge clk_i) begin
        lfsr = lfsr_step(lfsr);
        out_ready_i = lfsr[0];
    end

    // output monitor, checks order per id and that instructions never interleave
    always @(posedge clk_i) begin
        if (async_rst_ni && out_valid_o && out_ready_i) begin
            out_beats++;
            if (open_valid && value_mismatch("atomicity id", 32'(open_id), 32'(out_id_o)))
                mon_errors++;
            open_valid = !out_done_o;
            open_id    = out_id_o;
            if (exp_q[out_id_o].size() == 0) begin
                mon_errors++;
                $display("output beat for id %0d arrived while none was expected", out_id_o);
            end else begin
                mon_exp = exp_q[out_id_o].pop_front();
                if (value_mismatch($sformatf("id %0d vaddr", out_id_o), 32'(mon_exp[38:34]),
                                   32'(out_vaddr_o)))
                    mon_errors++;
                if (value_mismatch($sformatf("id %0d wr", out_id_o), 32'(mon_exp[33]),
                                   32'(out_wr_o)))
                    mon_errors++;
                if (value_mismatch($sformatf("id %0d done", out_id_o), 32'(mon_exp[0]),
                                   32'(out_done_o)))
                    mon_errors++;
                // store data is don't-care
                if (mon_exp[33] && value_mismatch($sformatf("id %0d data", out_id_o),
                                                  mon_exp[32:1], out_data_o))
                    mon_errors++;
            end
        end
    end

    task automatic apb_access(input logic write, input logic [3:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic slverr);
        int waited;
        waited = 0;
        @(negedge clk_i);
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = write;
        paddr_i   = addr;
        pwdata_i  = wdata;
        @(negedge clk_i);
        penable_i = 1'b1;
        @(posedge clk_i);
        while (!pready_o && waited < MAX_WAIT) begin
            waited++;
            @(posedge clk_i);
        end
        if (!pready_o) report_timeout("pready_o");
        rdata  = prdata_o;
        slverr = pslverr_o;
        @(negedge clk_i);
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        if (write && addr == ADDR_CTRL) ctrl_shadow = wdata[1:0];
    endtask

    // a beat for a disabled unit must stall 20 cycles, then the unit is enabled again
    task automatic send_beat(input logic [31:0] f_unit, input logic [31:0] f_op,
                             input logic [31:0] f_first, input logic [31:0] f_last,
                             input logic [31:0] f_id, input logic [31:0] f_vaddr,
                             input logic [31:0] f_opa, input logic [31:0] f_opb,
                             input logic [31:0] f_wr, input logic [31:0] f_data);
        int          waited;
        logic [31:0] rdata;
        logic        slverr;
        waited = 0;
        @(negedge clk_i);
        in_valid_i = 1'b1;
        in_unit_i  = unit_e'(f_unit[0]);
        in_op_i    = op_e'(f_op[2:0]);
        in_first_i = f_first[0];
        in_last_i  = f_last[0];
        in_id_i    = f_id[2:0];
        in_vaddr_i = f_vaddr[4:0];
        in_opa_i   = f_opa;
        in_opb_i   = f_opb;
        if (!ctrl_shadow[f_unit[0]]) begin
            repeat (20) begin
                @(posedge clk_i);
                if (value_mismatch("gated in_ready_o", 32'd0, 32'(in_ready_o))) errors++;
            end
            apb_access(1'b1, ADDR_CTRL, 32'(ctrl_shadow) | (32'd1 << f_unit[0]), rdata, slverr);
        end
        @(posedge clk_i);
        while (!in_ready_o && waited < MAX_WAIT) begin
            waited++;
            @(posedge clk_i);
        end
        if (!in_ready_o) begin
            report_timeout("in_ready_o");
        end else begin
            exp_q[f_id[2:0]].push_back({f_vaddr[4:0], f_wr[0], f_data, f_last[0]});
            in_beats++;
        end
    endtask

    task automatic release_input();
        if (in_valid_i) begin
            @(negedge clk_i);
            in_valid_i = 1'b0;
        end
    endtask

    task automatic drain_outputs();
        int waited;
        waited = 0;
        while (out_beats < in_beats && waited < MAX_WAIT) begin
            waited++;
            @(negedge clk_i);
        end
        if (out_beats < in_beats) report_timeout("the outstanding results");
    endtask

    initial begin
        int                fd;
        int                code;
        logic              reading_done;
        logic [7:0]        kind;
        logic [8*128-1:0]  line_buf;
        logic [31:0]       f [10];
        logic [31:0]       rdata;
        logic              slverr;
        in_valid_i   = 1'b0;
        in_unit_i    = UNIT_ARITH;
        in_op_i      = OP_ADD;
        in_first_i   = 1'b0;
        in_last_i    = 1'b0;
        in_id_i      = '0;
        in_vaddr_i   = '0;
        in_opa_i     = '0;
        in_opb_i     = '0;
        paddr_i      = '0;
        psel_i       = 1'b0;
        penable_i    = 1'b0;
        pwrite_i     = 1'b0;
        pwdata_i     = '0;
        reading_done = 1'b0;
        async_rst_ni = 1'b0;
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        async_rst_ni = 1'b1;

        fd = $fopen("vunit_patterns.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open vunit_patterns.txt");
        end
        while (fd != 0 && !reading_done && !timed_out) begin
            code = $fscanf(fd, " %c", kind);
            if (code != 1) begin
                reading_done = 1'b1;
            end else if (kind == "#") begin
                code = $fgets(line_buf, fd);
            end else if (kind == "I") begin
                code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2], f[3],
                               f[4], f[5], f[6], f[7], f[8], f[9]);
                if (code != 10) begin
                    errors++;
                    $display("beat line in the pattern file has %0d fields instead of 10", code);
                end
                send_beat(f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
            end else begin
                release_input();
                case (kind)
                    "W": begin
                        code = $fscanf(fd, "%h %h", f[0], f[1]);
                        apb_access(1'b1, f[0][3:0], f[1], rdata, slverr);
                    end
                    "R": begin
                        code = $fscanf(fd, "%h %h %h", f[0], f[1], f[2]);
                        apb_access(1'b0, f[0][3:0], 32'd0, rdata, slverr);
                        if (value_mismatch($sformatf("read 0x%0h data", f[0]), f[1], rdata))
                            errors++;
                        if (value_mismatch($sformatf("read 0x%0h pslverr", f[0]), f[2],
                                           32'(slverr)))
                            errors++;
                    end
                    "D": drain_outputs();
                    default: begin
                        errors++;
                        $display("unknown line kind '%c' in the pattern file", kind);
                    end
                endcase
            end
        end
        if (fd != 0) $fclose(fd);
        release_input();
        if (!timed_out) drain_outputs();

        if (value_mismatch("output beat count", 32'(in_beats), 32'(out_beats))) errors++;
        for (int i = 0; i < 8; i++) begin
            if (exp_q[i].size() != 0) begin
                errors++;
                $display("id %0d still waits for %0d results", i, exp_q[i].size());
            end
        end
        print_counts();
        if (errors + mon_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* vunit_patterns.txt */
# W addr wdata | R addr exp_rdata exp_slverr | D waits until all results are out
# I unit op first last id vaddr opa opb exp_wr exp_data (hex, op 0 add 1 sub 2 xor 3 mul 4 ld 5 st)
R 0 00000003 0
I 0 0 1 1 0 01 00000005 00000007 1 0000000c
I 0 1 1 1 1 02 00000003 00000005 1 fffffffe
I 0 2 1 1 2 03 f0f0f0f0 0ff00ff0 1 ff00ff00
I 0 3 1 1 3 04 00010003 00020005 1 000b000f
D
I 1 5 1 1 4 00 00000003 cafef00d 0 00000000
I 1 5 1 1 5 00 0000000a 12345678 0 00000000
D
I 1 4 1 1 4 06 00000003 00000000 1 cafef00d
I 1 4 1 1 5 07 0000001a 00000000 1 12345678
I 0 0 1 0 6 08 00000001 00000001 1 00000002
I 0 0 0 1 6 08 00000002 00000002 1 00000004
I 1 4 1 0 7 09 00000003 00000000 1 cafef00d
I 1 4 0 1 7 09 0000000a 00000000 1 12345678
I 0 3 1 0 0 0a 00000010 00000010 1 00000100
I 0 3 0 1 0 0a ffffffff 00000002 1 fffffffe
D
R 4 00000000 0
W 0 00000002
R 0 00000002 0
I 0 2 1 1 1 0b 0000ffff 00ff00ff 1 00ffff00
D
R 0 00000003 0
R 4 00000000 0
R 8 00000000 1

/* sources.f */
vmux_pkg.sv
pipe_stage.sv
arith_unit.sv
lsu_unit.sv
unit_scheduler.sv
apb_regs.sv
vunit_mux_top.sv
tb_vunit_mux.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds and runs the testbench with Verilator, the log decides pass or fail
set -u
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f sources.f --top-module tb_vunit_mux -o tb_vunit_mux
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_vunit_mux > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
    exit 1
fi
exit 0
